//--- mmuWalkSys.f
+incdir+design
design/pageTablePkg.sv
design/walkProtoPkg.sv
design/walkCtrlIf.sv
design/walkFsm.sv
design/levelCounter.sv
design/pteCheck.sv
design/walkAdrGen.sv
design/memPort.sv
design/mmuWalkSys.sv
verification/pageTableMem.sv
verification/mmuWalkSysTb.sv

//--- run_sim.sh
#!/bin/sh
# builds the walker testbench with Verilator, runs it and looks for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --top-module mmuWalkSysTb -f mmuWalkSys.f -o simWalk > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simWalk > sim.log 2>&1
grep -q "^TEST OK$" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }

//--- verification/mmuWalkSysTb.sv
// testbench for the Sv39 walker that builds a small page table in the memory model
// and checks every walk against a reference walk of the same table
`include "mmu_params.svh"

module mmuWalkSysTb import pageTablePkg::*, walkProtoPkg::*; ();

   localparam int timeout = 200;                   // cycles per wait
   localparam logic [7:0] fV = 8'h01;
   localparam logic [7:0] fR = 8'h02;
   localparam logic [7:0] fW = 8'h04;
   localparam logic [7:0] fX = 8'h08;
   localparam logic [`PPN_BITS-1:0] rootPpn = 44'h100;

   logic clk = 1'b0;
   logic rstN;
   logic [`PPN_BITS-1:0] satpPpn;
   logic missReq;
   logic missAck;
   logic [`VA_BITS-1:0] missVAdr;
   accessE missAccess;
   pteT walkPte;
   pageSizeE walkSize;
   faultE walkFault;
   logic memReq;
   logic memAck;
   logic [`PA_BITS-1:0] memAdr;
   logic [`PTE_BITS-1:0] memData;

   logic [`PTE_BITS-1:0] refTable [logic [`PA_BITS-1:0]]; // same entries as the model
   logic [`PA_BITS-1:0] expAdrQ [$];                     // reads the walk should make
   pteT expPte;
   pageSizeE expSize;
   faultE expFault;
   string curTest;
   integer seed = 32'h71c5_5d3a;
   int walkCount = 0;
   int respCount = 0;
   logic ackPrev = 1'b0;
   logic reqPrev = 1'b0;

   always #10 clk = ~clk;

   mmuWalkSys dut0 (
      .clk(clk), .rstN(rstN), .satpPpn(satpPpn),
      .missReq(missReq), .missVAdr(missVAdr), .missAccess(missAccess), .missAck(missAck),
      .walkPte(walkPte), .walkSize(walkSize), .walkFault(walkFault),
      .memReq(memReq), .memAdr(memAdr), .memAck(memAck), .memData(memData)
   );

   pageTableMem mem0 (
      .clk(clk), .rstN(rstN), .memReq(memReq), .memAdr(memAdr),
      .memAck(memAck), .memData(memData)
   );

   task automatic failRun(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic checkVal(input string what, input logic [63:0] expV, input logic [63:0] actV);
      if (expV !== actV) begin
         $display("[ERROR] %s %s: expected %h, actual %h", curTest, what, expV, actV);
         failRun("response differs from the reference walk");
      end
   endtask

   task automatic putPte(input logic [`PPN_BITS-1:0] tbl, input int idx,
                         input logic [`PPN_BITS-1:0] ppn, input logic [7:0] flags);
      logic [`PA_BITS-1:0]  a;
      logic [`PTE_BITS-1:0] e;
      a = {tbl, 9'(idx), 3'b000};
      e = {10'b0, ppn, 2'b00, flags};   // reserved bits, ppn, rsw and flags
      refTable[a] = e;
      mem0.ptes[a] = e;
   endtask

   function automatic logic [`VA_BITS-1:0] vaOf(input int v2, input int v1, input int v0);
      return {9'(v2), 9'(v1), 9'(v0), 12'h5a8};
   endfunction

   ////////////////////////////////////////////////////////////
   // reference walk by the Sv39 rules from the root down
   ////////////////////////////////////////////////////////////
   function automatic void refWalk(input logic [`VA_BITS-1:0] va, input accessE acc,
                                   output pteT pte, output pageSizeE size, output faultE flt);
      logic [`PPN_BITS-1:0] ppn;
      logic [`PA_BITS-1:0]  a;
      logic                 done;
      logic                 permOk;
      int                   lvl;
      ppn  = rootPpn;
      done = 1'b0;
      pte  = '0;
      size = kiloPage;
      flt  = invalidFault;
      for (lvl = `LEVELS - 1; lvl >= 0 && !done; lvl--) begin
         a = {ppn, va[`PAGE_OFFSET + `VPN_BITS * lvl +: `VPN_BITS], 3'b000};
         expAdrQ.push_back(a);
         pte  = refTable.exists(a) ? pteT'(refTable[a]) : '0;
         size = (lvl == 2) ? gigaPage : (lvl == 1) ? megaPage : kiloPage;
         permOk = (acc == fetch) ? pte.x : (acc == load) ? pte.r : pte.w;
         done = 1'b1;
         if (!pte.v || (pte.w && !pte.r)) begin
            flt = invalidFault;
         end else if (!pte.r && !pte.x) begin
            flt  = invalidFault;        // pointer entry is a fault only at the bottom
            ppn  = pte.ppn;
            done = (lvl == 0);
         end else if ((lvl == 2 && |pte.ppn[17:0]) || (lvl == 1 && |pte.ppn[8:0])) begin
            flt = misalignFault;
         end else begin
            flt = permOk ? noFault : permFault;
         end
      end
   endfunction

   task automatic runWalk(input string name, input logic [`VA_BITS-1:0] va, input accessE acc);
      int t;
      int hold;
      curTest = name;
      refWalk(va, acc, expPte, expSize, expFault);
      hold = int'($unsigned($random(seed)) % 4);   // late missReq drop
      @(negedge clk);
      missVAdr   <= va;
      missAccess <= acc;
      missReq    <= 1'b1;
      walkCount++;
      for (t = 0; t < timeout && !missAck; t++) @(negedge clk);
      if (!missAck) failRun($sformatf("%s: no missAck within the timeout", name));
      for (t = 0; t < hold; t++) @(negedge clk);
      missReq <= 1'b0;
      for (t = 0; t < timeout && missAck; t++) @(negedge clk);
      if (missAck) failRun($sformatf("%s: missAck stuck high after missReq fell", name));
   endtask

   ////////////////////////////////////////////////////////////
   // compare and handshake monitors
   ////////////////////////////////////////////////////////////
   always @(negedge clk) begin
      ackPrev <= missAck;
      if (rstN && missAck && !ackPrev) begin
         checkVal("entry", expPte, walkPte);
         checkVal("fault", 64'(expFault), 64'(walkFault));
         if (expFault == noFault) checkVal("size", 64'(expSize), 64'(walkSize));
         checkVal("reads left", 64'd0, 64'(expAdrQ.size()));
         respCount++;
      end else if (rstN && ackPrev && !missAck && missReq) begin
         failRun("missAck fell while missReq was still high");
      end
   end

   always @(negedge clk) begin
      reqPrev <= memReq;
      if (rstN && memReq && !reqPrev) begin
         if (memAck) begin
            failRun("memReq rose while memAck was still high");
         end else if (expAdrQ.size() == 0) begin
            failRun("memory read issued beyond the expected walk");
         end else begin
            checkVal("memAdr", 64'(expAdrQ.pop_front()), 64'(memAdr));
         end
      end
   end

   initial begin
      logic [31:0] r;
      rstN       = 1'b0;
      satpPpn    = rootPpn;
      missReq    = 1'b0;
      missVAdr   = '0;
      missAccess = fetch;
      putPte(rootPpn, 1, 44'h200, fV);              // pointer chain to a kilopage
      putPte(44'h200, 2, 44'h300, fV);
      putPte(44'h300, 3, 44'habcde, fV | fR | fW | fX | 8'hc0);
      putPte(44'h300, 4, 44'h777, fV | fW | fX);    // W without R
      putPte(44'h300, 5, 44'h888, fV);              // pointer at level 0
      putPte(44'h300, 6, 44'h999, fV | fR);
      putPte(44'h300, 7, 44'haaa, fV | fX);
      putPte(44'h300, 8, 44'h5, fX);                // V clear
      putPte(rootPpn, 4, 44'h40000, fV | fR | fX);  // gigapage
      putPte(rootPpn, 5, 44'h40001, fV | fR | fX);
      putPte(rootPpn, 6, 44'h600, fV);
      putPte(44'h600, 7, 44'h1200, fV | fR | fW);   // megapage
      putPte(44'h600, 8, 44'h1203, fV | fR | fW);
      putPte(44'h600, 9, 44'h5, fV | fW);
      putPte(44'h600, 10, 44'h5, fR);
      putPte(rootPpn, 10, 44'h5, fV | fW);
      putPte(rootPpn, 11, 44'h5, fR | fX);
      repeat (10) @(negedge clk);
      rstN <= 1'b1;
      runWalk("kilo fetch", vaOf(1, 2, 3), fetch);
      runWalk("kilo load", vaOf(1, 2, 3), load);
      runWalk("kilo store", vaOf(1, 2, 3), store);
      runWalk("giga leaf", vaOf(4, 17, 9), load);
      runWalk("giga misaligned", vaOf(5, 0, 0), fetch);
      runWalk("mega leaf", vaOf(6, 7, 1), store);
      runWalk("mega misaligned", vaOf(6, 8, 1), load);
      runWalk("unmapped level 2", vaOf(9, 0, 0), load);
      runWalk("W without R level 2", vaOf(10, 0, 0), load);
      runWalk("V clear level 2", vaOf(11, 0, 0), fetch);
      runWalk("W without R level 1", vaOf(6, 9, 0), load);
      runWalk("V clear level 1", vaOf(6, 10, 0), load);
      runWalk("W without R level 0", vaOf(1, 2, 4), store);
      runWalk("V clear level 0", vaOf(1, 2, 8), fetch);
      runWalk("pointer at level 0", vaOf(1, 2, 5), load);
      runWalk("no X for fetch", vaOf(1, 2, 6), fetch);
      runWalk("no W for store", vaOf(1, 2, 6), store);
      runWalk("R only load", vaOf(1, 2, 6), load);
      runWalk("no R for load", vaOf(1, 2, 7), load);
      runWalk("X only fetch", vaOf(1, 2, 7), fetch);
      for (int i = 0; i < 30; i++) begin
         r = $random(seed);
         runWalk($sformatf("random walk %0d", i),
                 vaOf(r[0] ? 1 : int'(r[7:4]), r[1] ? 2 : int'(r[11:8]), int'(r[15:12]) % 9),
                 (r[17:16] == 2'd0) ? fetch : (r[17:16] == 2'd1) ? load : store);
      end
      @(negedge clk);
      if (respCount == walkCount) begin
         $display("TEST OK");
         $finish;
      end else begin
         failRun($sformatf("%0d walks issued but %0d responses checked", walkCount, respCount));
      end
   end

endmodule

//--- verification/pageTableMem.sv
// page-table memory model for the walker testbench that answers four-phase reads
// the testbench writes entries into ptes and absent entries read as zero
`include "mmu_params.svh"

module pageTableMem (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 memReq,
   input  logic [`PA_BITS-1:0]  memAdr,
   output logic                 memAck,
   output logic [`PTE_BITS-1:0] memData
);

   logic [`PTE_BITS-1:0] ptes [logic [`PA_BITS-1:0]]; // sparse table keyed by byte address
   integer seed = 32'h71c5_5d3a;
   int     waitCnt = -1;    // cycles left before the next ack edge or -1 when none is due

   initial begin
      memAck  = 1'b0;
      memData = '0;
   end

   // inputs to the DUT change on the falling edge
   // ack rises a random delay after a new read and falls a random delay after req goes low
   always @(negedge clk) begin
      if (!rstN) begin
         memAck  <= 1'b0;
         waitCnt = -1;
      end else if (memReq != memAck) begin
         if (waitCnt < 0) begin
            waitCnt = int'($unsigned($random(seed)) % 4); // 0 to 3 cycles
         end
         if (waitCnt == 0) begin
            if (memReq) begin
               memData <= ptes.exists(memAdr) ? ptes[memAdr] : '0;
            end
            memAck  <= memReq;             // follow req once the delay is over
            waitCnt = -1;
         end else begin
            waitCnt = waitCnt - 1;
         end
      end
   end

endmodule

//--- design/mmuWalkSys.sv
// Sv39 page-table walker top, TLB miss port and table memory port
// wires the FSM to its level, check, address and memory blocks
`include "mmu_params.svh"

module mmuWalkSys import pageTablePkg::*, walkProtoPkg::*; (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic [`PPN_BITS-1:0] satpPpn,    // root page, stable during a walk
   // TLB side
   input  logic                 missReq,
   input  logic [`VA_BITS-1:0]  missVAdr,
   input  accessE               missAccess,
   output logic                 missAck,
   output pteT                  walkPte,    // valid while missAck high
   output pageSizeE             walkSize,
   output faultE                walkFault,
   // table memory side
   output logic                 memReq,
   output logic [`PA_BITS-1:0]  memAdr,
   input  logic                 memAck,
   input  logic [`PTE_BITS-1:0] memData
);

   logic [`PA_BITS-1:0] pteAdr;

   walkCtrlIf ctrl ();

   walkFsm fsm0 (
      .clk(clk), .rstN(rstN),
      .missReq(missReq), .missAck(missAck),
      .ctrl(ctrl.fsm)
   );

   levelCounter level0 (.clk(clk), .rstN(rstN), .lvl(ctrl.level));

   pteCheck check0 (
      .clk(clk), .rstN(rstN),
      .missAccess(missAccess),
      .chk(ctrl.check),
      .walkPte(walkPte), .walkFault(walkFault)
   );

   walkAdrGen adrGen0 (
      .clk(clk), .rstN(rstN),
      .missVAdr(missVAdr), .satpPpn(satpPpn),
      .adr(ctrl.adr),
      .pteAdr(pteAdr), .walkSize(walkSize)
   );

   memPort memPort0 (
      .clk(clk), .rstN(rstN),
      .pteAdr(pteAdr),
      .memReq(memReq), .memAdr(memAdr),
      .memAck(memAck), .memData(memData),
      .mem(ctrl.mem)
   );

endmodule

//--- design/memPort.sv
// four-phase read master toward page-table memory
// one read per readStart, data handed back with a readDone pulse
`include "mmu_params.svh"

module memPort import pageTablePkg::*; (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic [`PA_BITS-1:0]  pteAdr,
   output logic                 memReq,
   output logic [`PA_BITS-1:0]  memAdr,   // stable while memReq high
   input  logic                 memAck,
   input  logic [`PTE_BITS-1:0] memData,
   walkCtrlIf.mem mem
);

   logic pending; // read asked for, previous ack still up

   always_ff @(posedge clk) begin
      if (mem.readStart) begin
         memAdr <= pteAdr;
      end
   end

   // capture on the first cycle ack is seen
   always_ff @(posedge clk) begin
      if (memReq && memAck) begin
         mem.pteData <= pteT'(memData);
      end
   end

   ////////////////////////////////////////////////////////////
   // handshake
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rstN) begin
         memReq       <= 1'b0;
         pending      <= 1'b0;
         mem.readDone <= 1'b0;
      end else begin
         mem.readDone <= memReq && memAck;  // one pulse per read
         if (memReq) begin
            if (memAck) begin
               memReq <= 1'b0;              // phase 2, drop request
            end
         end else if (mem.readStart || pending) begin
            if (memAck) begin
               pending <= 1'b1;             // wait for ack low
            end else begin
               memReq  <= 1'b1;
               pending <= 1'b0;
            end
         end
      end
   end

endmodule

//--- design/walkAdrGen.sv
// entry address generation, root or previous ppn plus the vpn index
// also latches the miss address and the page size of the leaf
`include "mmu_params.svh"

module walkAdrGen import pageTablePkg::*; (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic [`VA_BITS-1:0]  missVAdr,
   input  logic [`PPN_BITS-1:0] satpPpn,   // root table page
   walkCtrlIf.adr adr,
   output logic [`PA_BITS-1:0]  pteAdr,    // address of the next entry
   output pageSizeE             walkSize
);

   logic [`VA_BITS-1:0]  vAdr;
   logic [`PPN_BITS-1:0] basePpn;
   logic [`VPN_BITS-1:0] vpnIdx;

   always_ff @(posedge clk) begin
      if (adr.startWalk) begin
         vAdr <= missVAdr;
      end
   end

   // root table at the top, else the table the pointer named
   assign basePpn = (adr.curLevel == 2'(`LEVELS - 1)) ? satpPpn : adr.pteData.ppn;

   always_comb begin
      case (adr.curLevel) // vpn field for this level
         2'd2:    vpnIdx = vAdr[`PAGE_OFFSET+2*`VPN_BITS +: `VPN_BITS]; // vpn2
         2'd1:    vpnIdx = vAdr[`PAGE_OFFSET+`VPN_BITS +: `VPN_BITS];   // vpn1
         default: vpnIdx = vAdr[`PAGE_OFFSET +: `VPN_BITS];            // vpn0
      endcase
   end

   assign pteAdr = {basePpn, vpnIdx, {`PTE_OFS{1'b0}}}; // 8 byte entries

   // size follows the level of the good leaf
   always_ff @(posedge clk) begin
      if (!rstN) begin
         walkSize <= kiloPage;
      end else if (adr.pteLeaf && !adr.pteFault) begin
         walkSize <= pageSizeE'(adr.curLevel);
      end
   end

endmodule

//--- design/pteCheck.sv
// entry register and decode, flags pointer, good leaf or fault
// fault priority is invalid, then misaligned, then permission
`include "mmu_params.svh"

module pteCheck import pageTablePkg::*, walkProtoPkg::*; (
   input  logic   clk,
   input  logic   rstN,
   input  accessE missAccess,  // held by the requester during the walk
   walkCtrlIf.check chk,
   output pteT    walkPte,     // final entry to the TLB
   output faultE  walkFault
);

   pteT   entry;        // last entry read
   logic  hasPte;       // entry belongs to this walk
   logic  badForm;
   logic  isLeaf;
   logic  ptrAtBottom;
   logic  superMisalign;
   logic  permOk;
   faultE faultKind;

   always_ff @(posedge clk) begin
      if (chk.readDone) begin
         entry <= chk.pteData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         hasPte <= 1'b0;
      end else if (chk.startWalk) begin
         hasPte <= 1'b0;     // old result no longer counts
      end else if (chk.readDone) begin
         hasPte <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // decode
   ////////////////////////////////////////////////////////////
   assign badForm     = !entry.v || (entry.w && !entry.r);
   assign isLeaf      = entry.r || entry.w || entry.x;
   assign ptrAtBottom = !isLeaf && chk.lastLevel;  // nowhere left to go

   // superpage needs the lower ppn fields clear
   always_comb begin
      case (chk.curLevel)
         2'd2:    superMisalign = |entry.ppn[2*`VPN_BITS-1:0]; // ppn1 and ppn0
         2'd1:    superMisalign = |entry.ppn[`VPN_BITS-1:0];   // ppn0
         default: superMisalign = 1'b0;
      endcase
   end

   always_comb begin
      case (missAccess)
         fetch:   permOk = entry.x;
         load:    permOk = entry.r;
         store:   permOk = entry.w;
         default: permOk = 1'b0;
      endcase
   end

   always_comb begin
      if (badForm || ptrAtBottom) begin
         faultKind = invalidFault;
      end else if (isLeaf && superMisalign) begin
         faultKind = misalignFault;
      end else if (isLeaf && !permOk) begin
         faultKind = permFault;   // only leaves carry permissions
      end else begin
         faultKind = noFault;
      end
   end

   assign chk.pteValid = hasPte && !badForm;
   assign chk.pteLeaf  = hasPte && !badForm && isLeaf;
   assign chk.pteFault = hasPte && (faultKind != noFault);

   assign walkPte   = entry;
   assign walkFault = faultKind;

endmodule

//--- design/levelCounter.sv
// current table level of the walk, counts down from the root
// read by the checker and the address generator
`include "mmu_params.svh"

module levelCounter (
   input  logic clk,
   input  logic rstN,
   walkCtrlIf.level lvl
);

   logic [1:0] level;

   // root level is the top of the table
   localparam logic [1:0] rootLevel = 2'(`LEVELS - 1);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         level <= '0;
      end else if (lvl.startWalk) begin
         level <= rootLevel;        // every walk starts at the root
      end else if (lvl.nextLevel && !lvl.lastLevel) begin
         level <= level - 2'd1;     // pointer followed
      end
   end

   // level 0 can only hold leaves
   assign lvl.curLevel  = level;
   assign lvl.lastLevel = (level == 2'd0);

endmodule

//--- design/walkFsm.sv
// walk sequencer, steps levels and runs the TLB side req/ack handshake
// commands are decoded from the state register
module walkFsm import walkProtoPkg::*; (
   input  logic clk,
   input  logic rstN,
   input  logic missReq,   // TLB miss request
   output logic missAck,   // response valid
   walkCtrlIf.fsm ctrl
);

   walkStateE state, nextState;

   ////////////////////////////////////////////////////////////
   // state register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= idle;
      end else begin
         state <= nextState;
      end
   end

   ////////////////////////////////////////////////////////////
   // next state
   ////////////////////////////////////////////////////////////
   always_comb begin
      nextState = state; // hold by default
      case (state)
         idle: begin
            if (missReq) begin
               nextState = adrPhase; // request captured on this edge
            end
         end
         adrPhase: begin
            nextState = memRead; // readStart goes out this cycle
         end
         memRead: begin
            if (ctrl.readDone) begin
               nextState = check; // entry lands in checker on same edge
            end
         end
         check: begin
            // fault wins, then good leaf, then pointer
            if (ctrl.pteFault) begin
               nextState = faultDone;
            end else if (ctrl.pteLeaf) begin
               nextState = leafDone;
            end else if (ctrl.pteValid) begin
               nextState = adrPhase; // descend one level
            end else begin
               nextState = faultDone;
            end
         end
         leafDone,
         faultDone: begin
            nextState = respond; // size and fault settle here
         end
         respond: begin
            if (!missReq) begin
               nextState = idle; // missAck drops next cycle
            end
         end
         default: begin
            nextState = idle;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // outputs
   ////////////////////////////////////////////////////////////
   assign ctrl.startWalk = (state == idle) && missReq;
   assign ctrl.readStart = (state == adrPhase);
   assign ctrl.nextLevel = (state == check) && ctrl.pteValid
                           && !ctrl.pteLeaf && !ctrl.pteFault; // pointer entry
   assign missAck        = (state == respond); // held until missReq low

endmodule

//--- design/walkCtrlIf.sv
// control and status between the walk FSM and its data blocks
// one instance in the top level, each block takes its own modport
interface walkCtrlIf import pageTablePkg::*; ();

   // commands from the FSM
   logic       startWalk;   // capture request, load level
   logic       nextLevel;   // pointer entry, step down
   logic       readStart;   // launch a table read

   // status from the data blocks
   logic       readDone;    // one cycle pulse, entry captured
   logic       pteValid;    // entry well formed
   logic       pteLeaf;     // entry is a leaf
   logic       pteFault;    // entry ends the walk with a fault
   logic       lastLevel;   // at level 0
   logic [1:0] curLevel;    // 2 down to 0
   pteT        pteData;     // entry returned by memory

   modport fsm   (output startWalk, nextLevel, readStart,
                  input  readDone, pteValid, pteLeaf, pteFault);
   modport level (input  startWalk, nextLevel,
                  output curLevel, lastLevel);
   modport check (input  startWalk, readDone, pteData, curLevel, lastLevel,
                  output pteValid, pteLeaf, pteFault);
   modport adr   (input  startWalk, curLevel, pteData, pteLeaf, pteFault);
   modport mem   (input  readStart,
                  output readDone, pteData);

endinterface

//--- design/walkProtoPkg.sv
// request, result and state encodings of the walker handshake
// imported by the FSM, the entry checker and the top level
package walkProtoPkg;

   // access kind of the miss, picks the permission bit
   typedef enum logic [1:0] {
      fetch = 2'd0,  // needs X
      load  = 2'd1,  // needs R
      store = 2'd2   // needs W
   } accessE;

   // fault reported with the response
   typedef enum logic [1:0] {
      noFault       = 2'd0,
      invalidFault  = 2'd1,  // V clear, W without R, or pointer at level 0
      misalignFault = 2'd2,  // superpage with nonzero low ppn
      permFault     = 2'd3   // leaf lacks the access permission
   } faultE;

   // walker FSM states
   typedef enum logic [2:0] {
      idle      = 3'd0,
      adrPhase  = 3'd1,  // entry address formed, read launched
      memRead   = 3'd2,  // waiting on the memory handshake
      check     = 3'd3,  // entry decoded
      leafDone  = 3'd4,
      faultDone = 3'd5,
      respond   = 3'd6   // missAck up until missReq drops
   } walkStateE;

endpackage

//--- design/pageTablePkg.sv
// Sv39 page-table entry layout and page size encoding
// used by the walker blocks that decode entries or report the page size
`include "mmu_params.svh"

package pageTablePkg;

   ////////////////////////////////////////////////////////////
   // entry format, msb first
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [`PTE_BITS-`PPN_BITS-11:0] reserved; // upper 10 bits, must be zero
      logic [`PPN_BITS-1:0]            ppn;      // ppn2 ppn1 ppn0
      logic [1:0]                      rsw;      // free for software
      logic                            d;        // dirty
      logic                            a;        // accessed
      logic                            g;        // global mapping
      logic                            u;        // user page
      logic                            x;        // executable
      logic                            w;        // writable
      logic                            r;        // readable
      logic                            v;        // valid
   } pteT;

   // size of the page a leaf maps
   // value matches the level the leaf was found on
   typedef enum logic [1:0] {
      kiloPage = 2'd0,  // leaf at level 0
      megaPage = 2'd1,  // leaf at level 1
      gigaPage = 2'd2   // leaf at level 2
   } pageSizeE;

endpackage

//--- design/mmu_params.svh
// widths and counts shared by the Sv39 walker blocks
// include wherever an address, page number or level count is sized
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

`define VA_BITS      39   // virtual address
`define PA_BITS      56   // physical address
`define PPN_BITS     44   // physical page number
`define LEVELS       3    // table levels in Sv39
`define PTE_BITS     64   // one table entry

// address slicing
`define VPN_BITS     9    // index per level
`define PAGE_OFFSET  12   // 4 KiB page offset
`define PTE_OFS      3    // log2 of entry size in bytes

`endif
